/* router_pkg.sv */
package router_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	localparam int W_CHAN = 16;			// bits per sample
	localparam int W_SEL = 3;			// bits per channel index
	localparam int N_IN = 8;			// channels from pid core
	localparam int N_OUT = 8;			// channels to output stage
	localparam int W_SETTLE = 3;			// settle counter width

	localparam int OUT_LIMIT = 30000;		// symmetric clamp bound
	localparam int SETTLE_CYCLES = 4;		// mute length after a write

	//////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////

	typedef logic signed [W_CHAN-1:0] chan_t;	// one sample
	typedef logic [W_SEL-1:0] sel_t;		// channel number
	typedef logic [N_OUT-1:0] mask_t;		// one bit per output
	typedef logic [W_SETTLE-1:0] settle_cnt_t;

	// channel i sits in slice i
	typedef chan_t [N_IN-1:0] in_bus_t;
	typedef chan_t [N_OUT-1:0] out_bus_t;

	//////////////////////////////////////////////////
	// command and controller types
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_ROUTE = 2'd0,			// set source of one output
		OP_ACTIVE = 2'd1,			// load activation mask
		OP_NOP = 2'd2				// settle only
	} cmd_op_t;

	// single frontpanel word, 16 bits
	typedef struct packed {
		cmd_op_t op;
		sel_t dest;
		sel_t src;
		mask_t mask;
	} fp_cmd_t;

	typedef struct packed {
		sel_t dest;				// output being rewired
		sel_t src;				// input it takes from
	} route_wr_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_SETTLE
	} fp_state_t;

endpackage

/* mux_n_chan.sv */
module mux_n_chan (
	input router_pkg::in_bus_t data_bus_in,	// all input channels
	input router_pkg::sel_t chan_select,	// which one to pass
	output router_pkg::chan_t data_out
);

	import router_pkg::*;

	// plain slice pick, no latency
	assign data_out = data_bus_in[chan_select];

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// the select comes from the router table
	// once live data flows through, an X select would smear X over the output
	always_comb begin
		if (!$isunknown(data_bus_in)) begin
			a_sel_known : assert final (!$isunknown(chan_select))
				else $error("mux select unknown while data is live");
		end
	end

endmodule

/* router.sv */
module router (
	input logic update_in,
	input logic reset,

	// from pid core
	input router_pkg::in_bus_t data_bus_in,

	// table writes from frontpanel controller
	input logic route_we,
	input router_pkg::route_wr_t route_wr,
	input logic active_we,
	input router_pkg::mask_t active_mask,

	// to output shaper
	output router_pkg::out_bus_t routed
);

	import router_pkg::*;

	//////////////////////////////////////////////////
	// routing tables
	//////////////////////////////////////////////////

	sel_t src_tbl [N_OUT];			// source per destination
	mask_t active_q;			// output enables
	chan_t mux_out [N_OUT];			// raw mux results

	// one write per cycle, at most one table at a time
	always_ff @(posedge update_in) begin
		if (reset) begin
			for (int i = 0; i < N_OUT; i++) begin
				src_tbl[i] <= '0;	// all outputs take input 0
			end
			active_q <= '0;			// everything off
		end else begin
			if (route_we) begin
				src_tbl[route_wr.dest] <= route_wr.src;
			end
			if (active_we) begin
				active_q <= active_mask;
			end
		end
	end

	//////////////////////////////////////////////////
	// data path, combinational
	//////////////////////////////////////////////////

	for (genvar g = 0; g < N_OUT; g++) begin : g_out
		mux_n_chan u_mux (
			.data_bus_in (data_bus_in),
			.chan_select (src_tbl[g]),
			.data_out (mux_out[g])
		);

		// inactive outputs read as zero
		assign routed[g] = active_q[g] ? mux_out[g] : '0;
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// controller issues only one kind of write per command
	a_one_write : assert property (
		@(posedge update_in) disable iff (reset)
		!(route_we && active_we)
	) else $error("route and mask written in the same cycle");

endmodule

/* settle_timer.sv */
module settle_timer (
	input logic update_in,
	input logic reset,
	input logic settle_start,		// pulse from controller
	output logic settle_busy		// mute level
);

	import router_pkg::*;

	settle_cnt_t cnt;			// remaining mute cycles

	//////////////////////////////////////////////////
	// down counter
	//////////////////////////////////////////////////

	always_ff @(posedge update_in) begin
		if (reset) begin
			cnt <= '0;
		end else if (settle_start) begin
			cnt <= settle_cnt_t'(SETTLE_CYCLES);	// reload full window
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// high from the start edge for SETTLE_CYCLES cycles
	assign settle_busy = (cnt != '0);

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// controller waits out the window before the next write
	// a restart here would stretch the mute silently
	a_no_restart : assert property (
		@(posedge update_in) disable iff (reset)
		settle_start |-> !settle_busy
	) else $error("settle start while still busy");

	// window length as seen from outside
	a_window_len : assert property (
		@(posedge update_in) disable iff (reset)
		settle_start |=> settle_busy [*SETTLE_CYCLES] ##1 !settle_busy
	) else $error("settle window has wrong length");

endmodule

/* frontpanel_ctrl.sv */
module frontpanel_ctrl (
	input logic update_in,
	input logic reset,

	// command word from frontpanel
	input router_pkg::fp_cmd_t cmd,
	input logic cmd_strobe,			// one cycle pulse

	// table writes to router
	output logic route_we,
	output router_pkg::route_wr_t route_wr,
	output logic active_we,
	output router_pkg::mask_t active_mask,

	// settle timer handshake
	output logic settle_start,
	input logic settle_busy,

	// status
	output logic busy,
	output logic cmd_drop			// strobe lost while busy
);

	import router_pkg::*;

	fp_state_t state;
	fp_state_t state_next;
	fp_cmd_t cmd_q;				// command held through the write

	logic accept;				// strobe taken this cycle

	assign accept = cmd_strobe && (state == ST_IDLE);

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (cmd_strobe) begin
					state_next = ST_WRITE;
				end
			end
			ST_WRITE: begin
				state_next = ST_SETTLE;	// write lasts one cycle
			end
			ST_SETTLE: begin
				if (!settle_busy) begin
					state_next = ST_IDLE;
				end
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge update_in) begin
		if (reset) begin
			state <= ST_IDLE;
			cmd_drop <= 1'b0;
		end else begin
			state <= state_next;
			cmd_drop <= cmd_strobe && (state != ST_IDLE);	// dropped, not queued
		end
	end

	// latch on acceptance only
	always_ff @(posedge update_in) begin
		if (accept) begin
			cmd_q <= cmd;
		end
	end

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	assign route_we = (state == ST_WRITE) && (cmd_q.op == OP_ROUTE);
	assign active_we = (state == ST_WRITE) && (cmd_q.op == OP_ACTIVE);
	assign route_wr = '{dest: cmd_q.dest, src: cmd_q.src};
	assign active_mask = cmd_q.mask;

	// every op settles, nop included
	assign settle_start = (state == ST_WRITE);

	assign busy = (state != ST_IDLE);

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// a table write belongs to the write state and the timer must pick it up
	a_write_then_mute : assert property (
		@(posedge update_in) disable iff (reset)
		(route_we || active_we) |-> (state == ST_WRITE) ##1 settle_busy
	) else $error("table write outside write state or not followed by mute");

endmodule

/* output_shaper.sv */
module output_shaper (
	input logic update_in,
	input logic reset,
	input router_pkg::out_bus_t routed,	// from router, combinational
	input logic mute,			// settle window open
	output router_pkg::out_bus_t data_bus_out
);

	import router_pkg::*;

	out_bus_t clamped;			// saturated copy of routed

	//////////////////////////////////////////////////
	// saturation
	//////////////////////////////////////////////////

	// clamp to +/- OUT_LIMIT
	function automatic chan_t clamp(input chan_t x);
		chan_t y;
		if (x > OUT_LIMIT) begin
			y = chan_t'(OUT_LIMIT);
		end else if (x < -OUT_LIMIT) begin
			y = chan_t'(-OUT_LIMIT);
		end else begin
			y = x;
		end
		return y;
	endfunction

	// per slice, no cross channel terms
	always_comb begin
		for (int i = 0; i < N_OUT; i++) begin
			clamped[i] = clamp(routed[i]);
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	always_ff @(posedge update_in) begin
		if (reset) begin
			data_bus_out <= '0;
		end else if (mute) begin
			data_bus_out <= '0;		// hide half written routes
		end else begin
			data_bus_out <= clamped;
		end
	end

endmodule

/* pid_route_top.sv */
module pid_route_top (
	input logic update_in,
	input logic reset,

	// pid core side
	input router_pkg::in_bus_t data_bus_in,

	// frontpanel side
	input router_pkg::fp_cmd_t cmd,
	input logic cmd_strobe,

	// output stage side
	output router_pkg::out_bus_t data_bus_out,
	output logic busy,
	output logic cmd_drop
);

	import router_pkg::*;

	//////////////////////////////////////////////////
	// internal wires
	//////////////////////////////////////////////////

	logic route_we;
	route_wr_t route_wr;
	logic active_we;
	mask_t active_mask;
	logic settle_start;
	logic settle_busy;			// doubles as mute
	out_bus_t routed;

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	frontpanel_ctrl u_ctrl (
		.update_in (update_in),
		.reset (reset),
		.cmd (cmd),
		.cmd_strobe (cmd_strobe),
		.route_we (route_we),
		.route_wr (route_wr),
		.active_we (active_we),
		.active_mask (active_mask),
		.settle_start (settle_start),
		.settle_busy (settle_busy),
		.busy (busy),
		.cmd_drop (cmd_drop)
	);

	settle_timer u_timer (
		.update_in (update_in),
		.reset (reset),
		.settle_start (settle_start),
		.settle_busy (settle_busy)
	);

	router u_router (
		.update_in (update_in),
		.reset (reset),
		.data_bus_in (data_bus_in),
		.route_we (route_we),
		.route_wr (route_wr),
		.active_we (active_we),
		.active_mask (active_mask),
		.routed (routed)
	);

	// one cycle from data_bus_in when not muted
	output_shaper u_shaper (
		.update_in (update_in),
		.reset (reset),
		.routed (routed),
		.mute (settle_busy),
		.data_bus_out (data_bus_out)
	);

endmodule

/* tb_pid_route.sv */
module tb_pid_route;

	timeunit 1ns;
	timeprecision 1ps;

	import router_pkg::*;

	localparam int N_RAND_CMDS = 40;
	localparam int MAX_CYCLES = N_RAND_CMDS * (SETTLE_CYCLES + 12) + 200;

	logic update_in;
	logic reset;
	in_bus_t data_bus_in;
	fp_cmd_t cmd;
	logic cmd_strobe;
	out_bus_t data_bus_out;
	logic busy;
	logic cmd_drop;

	logic [31:0] rng;			// xorshift state
	logic sat_data;				// out of range samples on the bus
	int cycle_cnt;
	int n_checks;
	int n_drops;				// drops the model expected and saw
	int n_clamped;				// clamped samples checked

	// model copy of the DUT registers, as they stand between edges
	sel_t [N_OUT-1:0] m_tbl;
	mask_t m_mask;
	int edge_no;				// last edge passed
	int acc_edge;				// edge that took the last command
	fp_cmd_t acc_cmd;
	out_bus_t exp_out;
	logic exp_busy;
	logic exp_drop;
	logic exp_valid;

	pid_route_top u_dut (
		.update_in (update_in),
		.reset (reset),
		.data_bus_in (data_bus_in),
		.cmd (cmd),
		.cmd_strobe (cmd_strobe),
		.data_bus_out (data_bus_out),
		.busy (busy),
		.cmd_drop (cmd_drop)
	);

	always #50 update_in = ~update_in;	// 100 ns period

	//////////////////////////////////////////////////
	// random source and reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// full range samples, or only values past the clamp bound
	function automatic in_bus_t gen_bus(input logic sat);
		in_bus_t d;
		logic [31:0] r;
		int mag;
		for (int i = 0; i < N_IN; i++) begin
			r = next_rand();
			if (sat) begin
				mag = 30001 + int'(r[15:0] % 16'd2767);	// 30001 .. 32767
				d[i] = chan_t'(r[31] ? -mag : mag);
			end else begin
				d[i] = chan_t'(r[15:0]);
			end
		end
		return d;
	endfunction

	function automatic fp_cmd_t make_cmd(input cmd_op_t op, input sel_t dest,
			input sel_t src, input mask_t mask);
		fp_cmd_t c;
		c.op = op;
		c.dest = dest;
		c.src = src;
		c.mask = mask;
		return c;
	endfunction

	// route, mask, then clamp to the symmetric bound
	function automatic out_bus_t model_out(input sel_t [N_OUT-1:0] tbl, input mask_t m,
			input in_bus_t d);
		out_bus_t o;
		int x;
		for (int i = 0; i < N_OUT; i++) begin
			x = m[i] ? int'(d[tbl[i]]) : 0;
			if (x > OUT_LIMIT) begin
				x = OUT_LIMIT;
			end else if (x < -OUT_LIMIT) begin
				x = -OUT_LIMIT;
			end
			o[i] = chan_t'(x);
		end
		return o;
	endfunction

	// busy after edge j, command taken at edge acc
	function automatic logic model_busy(input int j, input int acc);
		return (j >= acc) && (j <= acc + SETTLE_CYCLES + 1);
	endfunction

	// mute as sampled at edge j
	function automatic logic model_mute(input int j, input int acc);
		return (j >= acc + 2) && (j <= acc + SETTLE_CYCLES + 1);
	endfunction

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic stop_on_error(input string why);
		$display("tests failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_bus(input out_bus_t got, input out_bus_t exp, input string what);
		if (got !== exp) begin
			for (int i = 0; i < N_OUT; i++) begin
				if (got[i] !== exp[i]) begin
					$display("** Error at %0t ns: %s channel %0d is %0d, expected %0d",
						$time, what, i, got[i], exp[i]);
				end
			end
			stop_on_error("output bus mismatch");
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_on_error("status flag mismatch");
		end
	endtask

	// outputs are settled at the falling edge
	always @(negedge update_in) begin : compare
		int e;
		if (exp_valid) begin
			check_bus(data_bus_out, exp_out, "data_bus_out");
			check_flag(busy, exp_busy, "busy");
			check_flag(cmd_drop, exp_drop, "cmd_drop");
			n_checks++;
			n_drops += exp_drop;
			for (int i = 0; i < N_OUT; i++) begin
				if (exp_out[i] == OUT_LIMIT || exp_out[i] == -OUT_LIMIT) begin
					n_clamped++;
				end
			end
		end
		e = edge_no + 1;			// edge that samples the current inputs
		if (reset) begin
			m_tbl = '0;
			m_mask = '0;
			acc_edge = -100;
			exp_out = '0;
			exp_busy = 1'b0;
			exp_drop = 1'b0;
		end else begin
			// old tables hold through edge e, the write lands there
			exp_out = model_mute(e, acc_edge) ? '0 : model_out(m_tbl, m_mask, data_bus_in);
			if (e == acc_edge + 1) begin
				if (acc_cmd.op == OP_ROUTE) begin
					m_tbl[acc_cmd.dest] = acc_cmd.src;
				end else if (acc_cmd.op == OP_ACTIVE) begin
					m_mask = acc_cmd.mask;
				end
			end
			exp_drop = cmd_strobe && model_busy(e - 1, acc_edge);
			if (cmd_strobe && !model_busy(e - 1, acc_edge)) begin
				acc_edge = e;			// taken, write one edge later
				acc_cmd = cmd;
			end
			exp_busy = model_busy(e, acc_edge);
		end
		edge_no = e;
		exp_valid = 1'b1;
	end

	always @(posedge update_in) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
			stop_on_error("timeout");
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge update_in);
		data_bus_in <= gen_bus(sat_data);	// fresh samples every cycle
	endtask

	task automatic run_data(input int n);
		repeat (n) next_cycle();
	endtask

	// controller back in idle, busy low
	task automatic wait_idle();
		@(negedge update_in);
		while (busy) begin
			next_cycle();
			@(negedge update_in);
		end
	endtask

	// optional second strobe lands while the first one settles
	task automatic send_cmd(input fp_cmd_t c, input logic try_drop, input fp_cmd_t late);
		next_cycle();
		cmd <= c;
		cmd_strobe <= 1'b1;
		next_cycle();
		cmd_strobe <= 1'b0;
		if (try_drop) begin
			next_cycle();
			cmd <= late;
			cmd_strobe <= 1'b1;
			next_cycle();
			cmd_strobe <= 1'b0;
		end
		wait_idle();
	endtask

	initial begin
		fp_cmd_t c;
		fp_cmd_t late;
		logic [31:0] r;
		sel_t [N_OUT-1:0] srcs;

		update_in = 1'b0;
		reset = 1'b1;
		data_bus_in = '0;
		cmd = '0;
		cmd_strobe = 1'b0;
		sat_data = 1'b0;
		rng = 32'd6;
		cycle_cnt = 0;
		n_checks = 0;
		n_drops = 0;
		n_clamped = 0;
		edge_no = 0;
		acc_edge = -100;
		exp_valid = 1'b0;

		// reset with live data on the bus, mask stays zero after it
		run_data(5);
		reset <= 1'b0;
		run_data(4);
		@(negedge update_in);
		check_bus(data_bus_out, '0, "output after reset");
		check_flag(busy, 1'b0, "busy after reset");

		// outputs 0..2 all take input 3
		srcs = {3'd2, 3'd6, 3'd1, 3'd7, 3'd0, 3'd3, 3'd3, 3'd3};
		for (int d = 0; d < N_OUT; d++) begin
			send_cmd(make_cmd(OP_ROUTE, sel_t'(d), srcs[d], 8'h00), 1'b0, '0);
		end
		send_cmd(make_cmd(OP_ACTIVE, 3'd0, 3'd0, 8'hff), 1'b0, '0);
		run_data(12);

		// half the outputs off, rest keep streaming
		send_cmd(make_cmd(OP_ACTIVE, 3'd0, 3'd0, 8'b1010_0101), 1'b0, '0);
		run_data(12);

		// clamp both ways
		send_cmd(make_cmd(OP_ACTIVE, 3'd0, 3'd0, 8'hff), 1'b0, '0);
		sat_data = 1'b1;
		run_data(12);
		sat_data = 1'b0;

		send_cmd(make_cmd(OP_NOP, 3'd0, 3'd0, 8'h00), 1'b0, '0);	// mute only
		run_data(6);

		// dropped mask clear would blank every output
		late = make_cmd(OP_ACTIVE, 3'd0, 3'd0, 8'h00);
		send_cmd(make_cmd(OP_ROUTE, 3'd1, 3'd5, 8'h00), 1'b1, late);
		run_data(12);

		for (int i = 0; i < N_RAND_CMDS; i++) begin
			r = next_rand();
			c = make_cmd(cmd_op_t'(2'(r % 3)), sel_t'(r >> 4), sel_t'(r >> 8),
				mask_t'(r >> 12));
			late = make_cmd(cmd_op_t'(2'(r[29:28] % 2'd3)), sel_t'(r >> 7),
				sel_t'(r >> 11), mask_t'(r >> 3));
			sat_data = r[20];
			send_cmd(c, r[27:26] == 2'b00, late);
			run_data(int'(r[25:24]));
		end
		sat_data = 1'b0;
		run_data(4);

		if (n_checks > 0 && n_drops > 0 && n_clamped > 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("no drop or no clamp was seen: checks %0d, drops %0d, clamps %0d",
				n_checks, n_drops, n_clamped);
			stop_on_error("run did not reach every behavior");
		end
	end

endmodule

/* verilog.f */
router_pkg.sv
mux_n_chan.sv
router.sv
settle_timer.sv
frontpanel_ctrl.sv
output_shaper.sv
pid_route_top.sv
tb_pid_route.sv

/* Bender.yml */
package:
  name: pid_route

sources:
  - files:
      - router_pkg.sv
      - mux_n_chan.sv
      - router.sv
      - settle_timer.sv
      - frontpanel_ctrl.sv
      - output_shaper.sv
      - pid_route_top.sv
  - target: test
    files:
      - tb_pid_route.sv
